// ==== Bender.yml ====
package:
  name: zxuno_regbank

sources:
  - hdl/zxuno_pkg.sv
  - hdl/zxuno_bus_ctrl.sv
  - hdl/coreid.sv
  - hdl/option_regs.sv
  - hdl/rasterint_ctrl.sv
  - hdl/scandoubler_ctrl.sv
  - hdl/specdrum.sv
  - hdl/zxuno_regbank.sv
  - target: test
    files:
      - bench/zxuno_regbank_asserts.sv
      - bench/tb_zxuno_regbank.sv

// ==== bench/tb_zxuno_regbank.sv ====
`timescale 1ns/1ps

module tb_zxuno_regbank;

   localparam int CLK_PERIOD_NS = 10;
   localparam int NUM_ACCESSES  = 100;
   localparam int TIMEOUT_NS    = 4 * NUM_ACCESSES * 3 * CLK_PERIOD_NS;
   localparam logic [15:0] ADDR_PORT = zxuno_pkg::ZXUNO_ADDR_PORT;
   localparam logic [15:0] DATA_PORT = zxuno_pkg::ZXUNO_DATA_PORT;
   localparam logic [15:0] DRUM_PORT = {8'h1F, zxuno_pkg::SPECDRUM_PORT};

   logic        clk;
   logic        rst;
   logic [15:0] a;
   logic        iorq_n;
   logic        rd_n;
   logic        wr_n;
   logic [7:0]  din;
   logic        video_output_change;
   logic        raster_int_in_progress;
   logic [7:0]  dout;
   logic        vga_enable;
   logic        scanlines_enable;
   logic [2:0]  freq_option;
   logic [1:0]  turbo_enable;
   logic        csync_option;
   logic        rasterint_enable;
   logic        vretraceint_disable;
   logic [8:0]  raster_line;
   logic [7:0]  specdrum_audio;

   // Register model updated on every access the bench issues
   logic [7:0]  m_regnum;
   logic [7:0]  m_scratch;
   logic [7:0]  m_devopt;
   logic [7:0]  m_scandbl;
   logic [7:0]  m_rline;
   logic [2:0]  m_rctrl;
   logic [7:0]  m_drum;
   int          m_ptr;
   logic [63:0] id_text = "ZXREGB01";

   string       test_name;
   string       name_q[$];
   logic [15:0] exp_q[$];
   logic [15:0] act_q[$];
   int          n_checks = 0;
   int          n_errors = 0;

   zxuno_regbank u_zxuno_regbank (
      .cpuclkplain            (clk),
      .rst                    (rst),
      .a                      (a),
      .iorq_n                 (iorq_n),
      .rd_n                   (rd_n),
      .wr_n                   (wr_n),
      .din                    (din),
      .video_output_change    (video_output_change),
      .raster_int_in_progress (raster_int_in_progress),
      .dout                   (dout),
      .vga_enable             (vga_enable),
      .scanlines_enable       (scanlines_enable),
      .freq_option            (freq_option),
      .turbo_enable           (turbo_enable),
      .csync_option           (csync_option),
      .rasterint_enable       (rasterint_enable),
      .vretraceint_disable    (vretraceint_disable),
      .raster_line            (raster_line),
      .specdrum_audio         (specdrum_audio)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD_NS / 2) clk = ~clk;
   end

   // ----------------------------------------------------------------------
   // Reference model
   // ----------------------------------------------------------------------
   function automatic logic [7:0] expected_read(input logic [15:0] addr);
      logic [7:0] val;
      val = 8'hFF;
      if (addr == ADDR_PORT) begin
         val = m_regnum;
      end else if (addr == DATA_PORT) begin
         case (m_regnum)
            8'hFF:   val = (m_ptr < 8) ? id_text[63 - 8 * m_ptr -: 8] : 8'h00;
            8'hFE:   val = m_scratch;
            8'h0E:   val = m_devopt;
            8'h0B:   val = m_scandbl;
            8'h0C:   val = m_rline;
            8'h0D:   val = {raster_int_in_progress, 4'b0000, m_rctrl};
            default: val = 8'hFF;
         endcase
      end
      return val;
   endfunction

   function automatic void model_write(input logic [15:0] addr, input logic [7:0] data);
      if (addr == ADDR_PORT) begin
         m_regnum = data;
         m_ptr    = 0;
      end else if (addr == DATA_PORT) begin
         case (m_regnum)
            8'hFE:   m_scratch = data;
            8'h0E:   m_devopt  = data;
            8'h0B:   m_scandbl = data;
            8'h0C:   m_rline   = data;
            8'h0D:   m_rctrl   = data[2:0];
            default: ;
         endcase
      end else if (addr[7:0] == 8'hDF && !m_devopt[7]) begin
         m_drum = data;
      end
   endfunction

   function automatic logic [7:0] rand_byte();
      logic [31:0] r;
      r = $urandom;
      return r[7:0];
   endfunction

   // ----------------------------------------------------------------------
   // Bus tasks and check queue
   // ----------------------------------------------------------------------
   task automatic check_val(input string what, input logic [15:0] exp_v,
                            input logic [15:0] act_v);
      name_q.push_back($sformatf("%s %s", test_name, what));
      exp_q.push_back(exp_v);
      act_q.push_back(act_v);
   endtask

   task automatic check_ports();
      @(negedge clk);
      check_val("vga_enable", m_scandbl[0], vga_enable);
      check_val("scanlines_enable", m_scandbl[1], scanlines_enable);
      check_val("freq_option", m_scandbl[4:2], freq_option);
      check_val("csync_option", m_scandbl[5], csync_option);
      check_val("turbo_enable", m_scandbl[7:6], turbo_enable);
      check_val("raster_line", {m_rctrl[0], m_rline}, raster_line);
      check_val("rasterint_enable", m_rctrl[1], rasterint_enable);
      check_val("vretraceint_disable", m_rctrl[2], vretraceint_disable);
      check_val("specdrum_audio", m_drum, specdrum_audio);
   endtask

   task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
      @(posedge clk);
      a      <= addr;
      din    <= data;
      iorq_n <= 1'b0;
      wr_n   <= 1'b0;
      @(posedge clk);
      @(posedge clk);
      iorq_n <= 1'b1;
      wr_n   <= 1'b1;
      model_write(addr, data);
      check_ports();
   endtask

   task automatic io_read(input logic [15:0] addr);
      @(posedge clk);
      a      <= addr;
      iorq_n <= 1'b0;
      rd_n   <= 1'b0;
      @(posedge clk);
      @(negedge clk);
      check_val($sformatf("read %h", addr), expected_read(addr), dout);
      @(posedge clk);
      iorq_n <= 1'b1;
      rd_n   <= 1'b1;
      // Identity pointer steps once the read is over
      if (addr == DATA_PORT && m_regnum == 8'hFF)
         m_ptr = (m_ptr == 8) ? 0 : m_ptr + 1;
   endtask

   task automatic toggle_video();
      @(posedge clk);
      video_output_change <= 1'b1;
      @(posedge clk);
      video_output_change <= 1'b0;
      m_scandbl[0] = ~m_scandbl[0];
      check_ports();
   endtask

   initial begin : compare
      string       nm;
      logic [15:0] e;
      logic [15:0] g;
      forever begin
         wait (act_q.size() != 0);
         nm = name_q.pop_front();
         e  = exp_q.pop_front();
         g  = act_q.pop_front();
         n_checks++;
         if (e !== g) begin
            n_errors++;
            $display("** Error %s: expected 0x%0h, actual 0x%0h", nm, e, g);
         end
      end
   end

   initial begin : watchdog
      #(TIMEOUT_NS);
      $display("Timeout: tests still running after %0d ns, %0d errors so far",
               TIMEOUT_NS, n_errors);
      $display("** FAIL **");
      $finish;
   end

   // ----------------------------------------------------------------------
   // Stimulus
   // ----------------------------------------------------------------------
   initial begin : stimulus
      int i;
      int n_assert_fails;
      void'($urandom(32'h3151));
      rst                    <= 1'b1;
      a                      <= 16'h0000;
      iorq_n                 <= 1'b1;
      rd_n                   <= 1'b1;
      wr_n                   <= 1'b1;
      din                    <= 8'h00;
      video_output_change    <= 1'b0;
      raster_int_in_progress <= 1'b0;
      m_regnum  = 8'h00;
      m_scratch = 8'h00;
      m_devopt  = 8'h00;
      m_scandbl = 8'h00;
      m_rline   = 8'h00;
      m_rctrl   = 3'b000;
      m_drum    = 8'h80;
      m_ptr     = 0;
      repeat (16) @(posedge clk);
      rst <= 1'b0;

      test_name = "reset";
      io_read(ADDR_PORT);
      check_ports();
      check_val("idle bus", 8'hFF, dout);
      io_read(16'h7FFE);

      test_name = "scratch";
      io_write(ADDR_PORT, 8'h5A);
      io_read(ADDR_PORT);
      io_write(ADDR_PORT, zxuno_pkg::REG_SCRATCH);
      for (i = 0; i < 8; i++) begin
         io_write(DATA_PORT, rand_byte());
         io_read(DATA_PORT);
      end
      test_name = "undecoded";
      for (i = 0; i < 3; i++) begin
         io_write(ADDR_PORT, 8'h33 + 8'h22 * i);
         io_read(DATA_PORT);
      end

      // Twelve reads run past the zero byte and wrap
      test_name = "coreid";
      io_write(ADDR_PORT, zxuno_pkg::REG_COREID);
      for (i = 0; i < 12; i++)
         io_read(DATA_PORT);
      io_write(ADDR_PORT, zxuno_pkg::REG_COREID);
      io_read(DATA_PORT);

      test_name = "raster";
      for (i = 0; i < 4; i++) begin
         io_write(ADDR_PORT, zxuno_pkg::REG_RASTERLINE);
         io_write(DATA_PORT, rand_byte());
         io_read(DATA_PORT);
         io_write(ADDR_PORT, zxuno_pkg::REG_RASTERCTRL);
         io_write(DATA_PORT, rand_byte());
         @(posedge clk);
         raster_int_in_progress <= i[0];
         io_read(DATA_PORT);
      end

      test_name = "scandoubler";
      io_write(ADDR_PORT, zxuno_pkg::REG_SCANDBLCTRL);
      for (i = 0; i < 4; i++) begin
         io_write(DATA_PORT, rand_byte());
         io_read(DATA_PORT);
      end
      test_name = "video toggle";
      for (i = 0; i < 2; i++) begin
         toggle_video();
         io_read(DATA_PORT);
      end

      test_name = "specdrum";
      for (i = 0; i < 3; i++)
         io_write(DRUM_PORT, rand_byte());
      io_write(ADDR_PORT, zxuno_pkg::REG_DEVOPTIONS);
      io_write(DATA_PORT, 8'h80);
      io_read(DATA_PORT);
      // Inverted byte so a missed block always shows
      for (i = 0; i < 2; i++)
         io_write(DRUM_PORT, ~m_drum);
      io_write(DATA_PORT, 8'h00);
      io_write(DRUM_PORT, ~m_drum);

      wait (act_q.size() == 0);
      @(negedge clk);
      n_assert_fails = u_zxuno_regbank.u_bus_ctrl.u_asserts.n_failures;
      $display("Finished: %0d checks, %0d errors, %0d assertion failures",
               n_checks, n_errors, n_assert_fails);
      if (n_errors == 0 && n_assert_fails == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

// ==== bench/zxuno_regbank_asserts.sv ====
`timescale 1ns/1ps

module zxuno_regbank_asserts (
   input logic clk,
   input logic rst,
   input logic zxuno_regrd,
   input logic zxuno_regwr,
   input logic regaddr_changed
);

   int n_failures = 0;

   // ----------------------------------------------------------------------
   // Strobes are single-cycle pulses
   // ----------------------------------------------------------------------
   regrd_one_cycle: assert property (@(posedge clk) disable iff (rst)
      zxuno_regrd |=> !zxuno_regrd)
      else begin
         $error("zxuno_regrd stayed high for more than one cycle");
         n_failures++;
      end

   regwr_one_cycle: assert property (@(posedge clk) disable iff (rst)
      zxuno_regwr |=> !zxuno_regwr)
      else begin
         $error("zxuno_regwr stayed high for more than one cycle");
         n_failures++;
      end

   addr_chg_one_cycle: assert property (@(posedge clk) disable iff (rst)
      regaddr_changed |=> !regaddr_changed)
      else begin
         $error("regaddr_changed stayed high for more than one cycle");
         n_failures++;
      end

   // A read and a write never strobe together
   rd_wr_exclusive: assert property (@(posedge clk) disable iff (rst)
      !(zxuno_regrd && zxuno_regwr))
      else begin
         $error("zxuno_regrd and zxuno_regwr high in the same cycle");
         n_failures++;
      end

   // Edge flags only hold their reset value after the first reset edge
   quiet_in_reset: assert property (@(posedge clk)
      rst && $past(rst) |-> !(zxuno_regrd || zxuno_regwr || regaddr_changed))
      else begin
         $error("Bus strobe high while rst is asserted");
         n_failures++;
      end

endmodule

bind zxuno_bus_ctrl zxuno_regbank_asserts u_asserts (
   .clk             (clk),
   .rst             (rst),
   .zxuno_regrd     (zxuno_regrd),
   .zxuno_regwr     (zxuno_regwr),
   .regaddr_changed (regaddr_changed)
);

// ==== hdl/coreid.sv ====
`timescale 1ns/1ps

module coreid (
   input  logic                          clk,
   input  logic                          rst,
   input  logic [zxuno_pkg::DATA_W-1:0]  zxuno_addr,
   input  logic                          zxuno_regrd,
   input  logic                          regaddr_changed,
   input  logic                          data_rd,
   output logic [zxuno_pkg::DATA_W-1:0]  dout,
   output logic                          oe
);

   // One extra position for the terminating zero byte
   localparam int PTR_W = $clog2(zxuno_pkg::COREID_LEN + 1);

   logic [PTR_W-1:0] ptr;
   logic             sel;

   assign sel = (zxuno_addr == zxuno_pkg::REG_COREID);
   assign oe  = data_rd && sel;

   always_ff @(posedge clk) begin
      if (rst) begin
         ptr <= '0;
      end else if (regaddr_changed) begin
         ptr <= '0;
      end else if (zxuno_regrd && sel) begin
         if (ptr == PTR_W'(zxuno_pkg::COREID_LEN))
            ptr <= '0;
         else
            ptr <= ptr + 1'b1;
      end
   end

   // First character sits in the top byte of the string
   always_comb begin
      if (ptr < PTR_W'(zxuno_pkg::COREID_LEN))
         dout = zxuno_pkg::COREID_CHARS[
            (zxuno_pkg::COREID_LEN - 1 - int'(ptr)) * zxuno_pkg::DATA_W +: zxuno_pkg::DATA_W];
      else
         dout = '0;
   end

endmodule

// ==== hdl/option_regs.sv ====
`timescale 1ns/1ps

module option_regs (
   input  logic                          clk,
   input  logic                          rst,
   input  logic [zxuno_pkg::DATA_W-1:0]  zxuno_addr,
   input  logic                          zxuno_regwr,
   input  logic                          data_rd,
   input  logic [zxuno_pkg::DATA_W-1:0]  din,
   output logic [zxuno_pkg::DATA_W-1:0]  dout,
   output logic                          oe,
   output logic                          disable_specdrum
);

   logic [zxuno_pkg::DATA_W-1:0] scratch;
   logic [zxuno_pkg::DATA_W-1:0] devoptions;
   logic                         sel_scratch;
   logic                         sel_devopt;

   assign sel_scratch = (zxuno_addr == zxuno_pkg::REG_SCRATCH);
   assign sel_devopt  = (zxuno_addr == zxuno_pkg::REG_DEVOPTIONS);

   always_ff @(posedge clk) begin
      if (rst) begin
         scratch    <= '0;
         devoptions <= '0;
      end else if (zxuno_regwr) begin
         if (sel_scratch)
            scratch <= din;
         if (sel_devopt)
            devoptions <= din;
      end
   end

   // Only the drum bit acts on anything here
   assign disable_specdrum = devoptions[zxuno_pkg::DEVOPT_SPECDRUM_BIT];

   // Readback
   assign oe   = data_rd && (sel_scratch || sel_devopt);
   assign dout = sel_scratch ? scratch : devoptions;

endmodule

// ==== hdl/rasterint_ctrl.sv ====
`timescale 1ns/1ps

module rasterint_ctrl (
   input  logic                            clk,
   input  logic                            rst,
   input  logic [zxuno_pkg::DATA_W-1:0]    zxuno_addr,
   input  logic                            zxuno_regwr,
   input  logic                            data_rd,
   input  logic [zxuno_pkg::DATA_W-1:0]    din,
   input  logic                            raster_int_in_progress,
   output logic [zxuno_pkg::DATA_W-1:0]    dout,
   output logic                            oe,
   output logic [zxuno_pkg::RASTER_W-1:0]  raster_line,
   output logic                            rasterint_enable,
   output logic                            vretraceint_disable
);

   logic sel_line;
   logic sel_ctrl;

   assign sel_line = (zxuno_addr == zxuno_pkg::REG_RASTERLINE);
   assign sel_ctrl = (zxuno_addr == zxuno_pkg::REG_RASTERCTRL);

   always_ff @(posedge clk) begin
      if (rst) begin
         raster_line         <= '0;
         rasterint_enable    <= 1'b0;
         vretraceint_disable <= 1'b0;
      end else if (zxuno_regwr) begin
         if (sel_line)
            raster_line[zxuno_pkg::DATA_W-1:0] <= din;
         if (sel_ctrl) begin
            // Line bit 8 lives in the control register
            raster_line[zxuno_pkg::RASTER_W-1] <= din[0];
            rasterint_enable                   <= din[1];
            vretraceint_disable                <= din[2];
         end
      end
   end

   assign oe = data_rd && (sel_line || sel_ctrl);

   always_comb begin
      if (sel_line)
         dout = raster_line[zxuno_pkg::DATA_W-1:0];
      else
         dout = {raster_int_in_progress, 4'b0000, vretraceint_disable,
                 rasterint_enable, raster_line[zxuno_pkg::RASTER_W-1]};
   end

endmodule

// ==== hdl/scandoubler_ctrl.sv ====
`timescale 1ns/1ps

module scandoubler_ctrl (
   input  logic                          clk,
   input  logic                          rst,
   input  logic [zxuno_pkg::DATA_W-1:0]  zxuno_addr,
   input  logic                          zxuno_regwr,
   input  logic                          data_rd,
   input  logic [zxuno_pkg::DATA_W-1:0]  din,
   input  logic                          video_output_change,
   output logic [zxuno_pkg::DATA_W-1:0]  dout,
   output logic                          oe,
   output logic                          vga_enable,
   output logic                          scanlines_enable,
   output logic [2:0]                    freq_option,
   output logic [1:0]                    turbo_enable,
   output logic                          csync_option
);

   logic [zxuno_pkg::DATA_W-1:0] ctrl;
   logic                         sel;

   assign sel = (zxuno_addr == zxuno_pkg::REG_SCANDBLCTRL);

   // CPU write takes priority over the keyboard toggle
   always_ff @(posedge clk) begin
      if (rst) begin
         ctrl <= '0;
      end else if (zxuno_regwr && sel) begin
         ctrl <= din;
      end else if (video_output_change) begin
         ctrl[0] <= ~ctrl[0];
      end
   end

   // Field layout of register 0B
   assign vga_enable       = ctrl[0];
   assign scanlines_enable = ctrl[1];
   assign freq_option      = ctrl[4:2];
   assign csync_option     = ctrl[5];
   assign turbo_enable     = ctrl[7:6];

   assign oe   = data_rd && sel;
   assign dout = ctrl;

endmodule

// ==== hdl/specdrum.sv ====
`timescale 1ns/1ps

module specdrum (
   input  logic                          clk,
   input  logic                          rst,
   input  logic [zxuno_pkg::ADDR_W-1:0]  a,
   input  logic                          iorq_n,
   input  logic                          wr_n,
   input  logic [zxuno_pkg::DATA_W-1:0]  din,
   input  logic                          disable_specdrum,
   output logic [zxuno_pkg::DATA_W-1:0]  specdrum_audio
);

   logic port_wr;
   logic port_wr_q;

   // Partial decode, only the low address byte matters
   assign port_wr = !iorq_n && !wr_n && (a[7:0] == zxuno_pkg::SPECDRUM_PORT);

   always_ff @(posedge clk) begin
      if (rst) begin
         port_wr_q      <= 1'b0;
         specdrum_audio <= zxuno_pkg::SPECDRUM_RESET;
      end else begin
         port_wr_q <= port_wr;
         if (port_wr && !port_wr_q && !disable_specdrum)
            specdrum_audio <= din;
      end
   end

endmodule

// ==== hdl/zxuno_bus_ctrl.sv ====
`timescale 1ns/1ps

module zxuno_bus_ctrl (
   input  logic                          clk,
   input  logic                          rst,
   input  logic [zxuno_pkg::ADDR_W-1:0]  a,
   input  logic                          iorq_n,
   input  logic                          rd_n,
   input  logic                          wr_n,
   input  logic [zxuno_pkg::DATA_W-1:0]  din,
   input  logic                          coreid_oe,
   input  logic [zxuno_pkg::DATA_W-1:0]  coreid_dout,
   input  logic                          options_oe,
   input  logic [zxuno_pkg::DATA_W-1:0]  options_dout,
   input  logic                          raster_oe,
   input  logic [zxuno_pkg::DATA_W-1:0]  raster_dout,
   input  logic                          scandbl_oe,
   input  logic [zxuno_pkg::DATA_W-1:0]  scandbl_dout,
   output logic [zxuno_pkg::DATA_W-1:0]  dout,
   output logic [zxuno_pkg::DATA_W-1:0]  zxuno_addr,
   output logic                          zxuno_regrd,
   output logic                          zxuno_regwr,
   output logic                          regaddr_changed,
   output logic                          data_rd
);

   logic addr_sel;
   logic data_sel;
   logic addr_wr;
   logic addr_rd;
   logic data_wr;
   logic addr_wr_q;
   logic data_wr_q;
   logic data_rd_q;
   zxuno_pkg::rd_source_t rd_src;

   // ----------------------------------------------------------------------
   // Port decode
   // ----------------------------------------------------------------------
   assign addr_sel = !iorq_n && (a == zxuno_pkg::ZXUNO_ADDR_PORT);
   assign data_sel = !iorq_n && (a == zxuno_pkg::ZXUNO_DATA_PORT);

   assign addr_wr = addr_sel && !wr_n;
   assign addr_rd = addr_sel && !rd_n;
   assign data_wr = data_sel && !wr_n;
   assign data_rd = data_sel && !rd_n;

   // Previous cycle's access, for edge detection
   always_ff @(posedge clk) begin
      if (rst) begin
         addr_wr_q <= 1'b0;
         data_wr_q <= 1'b0;
         data_rd_q <= 1'b0;
      end else begin
         addr_wr_q <= addr_wr;
         data_wr_q <= data_wr;
         data_rd_q <= data_rd;
      end
   end

   // Writes strobe on their first cycle, reads once they are over
   assign regaddr_changed = addr_wr && !addr_wr_q;
   assign zxuno_regwr     = data_wr && !data_wr_q;
   assign zxuno_regrd     = data_rd_q && !data_rd;

   // Register number, loaded once per write to FC3B
   always_ff @(posedge clk) begin
      if (rst) begin
         zxuno_addr <= '0;
      end else if (regaddr_changed) begin
         zxuno_addr <= din;
      end
   end

   // ----------------------------------------------------------------------
   // Read data toward the CPU
   // ----------------------------------------------------------------------
   // Register number readback comes first
   always_comb begin
      if (addr_rd)
         rd_src = zxuno_pkg::SRC_ADDR;
      else if (coreid_oe)
         rd_src = zxuno_pkg::SRC_COREID;
      else if (options_oe)
         rd_src = zxuno_pkg::SRC_OPTIONS;
      else if (raster_oe)
         rd_src = zxuno_pkg::SRC_RASTER;
      else if (scandbl_oe)
         rd_src = zxuno_pkg::SRC_SCANDBL;
      else
         rd_src = zxuno_pkg::SRC_NONE;
   end

   always_comb begin
      case (rd_src)
         zxuno_pkg::SRC_ADDR:    dout = zxuno_addr;
         zxuno_pkg::SRC_COREID:  dout = coreid_dout;
         zxuno_pkg::SRC_OPTIONS: dout = options_dout;
         zxuno_pkg::SRC_RASTER:  dout = raster_dout;
         zxuno_pkg::SRC_SCANDBL: dout = scandbl_dout;
         default:                dout = zxuno_pkg::IDLE_BUS;
      endcase
   end

endmodule

// ==== hdl/zxuno_pkg.sv ====
package zxuno_pkg;

   // ----------------------------------------------------------------------
   // Bus widths
   // ----------------------------------------------------------------------
   localparam int ADDR_W   = 16;
   localparam int DATA_W   = 8;
   localparam int RASTER_W = 9;

   // I/O ports of the register bank and the drum DAC
   localparam logic [ADDR_W-1:0] ZXUNO_ADDR_PORT = 16'hFC3B;
   localparam logic [ADDR_W-1:0] ZXUNO_DATA_PORT = 16'hFD3B;
   localparam logic [DATA_W-1:0] SPECDRUM_PORT   = 8'hDF;

   // ----------------------------------------------------------------------
   // Register numbers behind the data port
   // ----------------------------------------------------------------------
   localparam logic [DATA_W-1:0] REG_COREID      = 8'hFF;
   localparam logic [DATA_W-1:0] REG_SCRATCH     = 8'hFE;
   localparam logic [DATA_W-1:0] REG_DEVOPTIONS  = 8'h0E;
   localparam logic [DATA_W-1:0] REG_SCANDBLCTRL = 8'h0B;
   localparam logic [DATA_W-1:0] REG_RASTERLINE  = 8'h0C;
   localparam logic [DATA_W-1:0] REG_RASTERCTRL  = 8'h0D;

   // Identity string, first character in the top byte
   localparam int COREID_LEN = 8;
   localparam logic [COREID_LEN*DATA_W-1:0] COREID_CHARS = "ZXREGB01";

   // Undriven bus and DAC midpoint
   localparam logic [DATA_W-1:0] IDLE_BUS       = 8'hFF;
   localparam logic [DATA_W-1:0] SPECDRUM_RESET = 8'h80;

   localparam int DEVOPT_SPECDRUM_BIT = 7;

   // Who owns the CPU data bus during a read
   typedef enum logic [2:0] {
      SRC_NONE,
      SRC_ADDR,
      SRC_COREID,
      SRC_OPTIONS,
      SRC_RASTER,
      SRC_SCANDBL
   } rd_source_t;

endpackage

// ==== hdl/zxuno_regbank.sv ====
`timescale 1ns/1ps

module zxuno_regbank (
   input  logic                            cpuclkplain,
   input  logic                            rst,
   input  logic [zxuno_pkg::ADDR_W-1:0]    a,
   input  logic                            iorq_n,
   input  logic                            rd_n,
   input  logic                            wr_n,
   input  logic [zxuno_pkg::DATA_W-1:0]    din,
   input  logic                            video_output_change,
   input  logic                            raster_int_in_progress,
   output logic [zxuno_pkg::DATA_W-1:0]    dout,
   output logic                            vga_enable,
   output logic                            scanlines_enable,
   output logic [2:0]                      freq_option,
   output logic [1:0]                      turbo_enable,
   output logic                            csync_option,
   output logic                            rasterint_enable,
   output logic                            vretraceint_disable,
   output logic [zxuno_pkg::RASTER_W-1:0]  raster_line,
   output logic [zxuno_pkg::DATA_W-1:0]    specdrum_audio
);

   // ----------------------------------------------------------------------
   // Register bus between the controller and the units
   // ----------------------------------------------------------------------
   logic [zxuno_pkg::DATA_W-1:0] zxuno_addr;
   logic                         zxuno_regrd;
   logic                         zxuno_regwr;
   logic                         regaddr_changed;
   logic                         data_rd;

   logic                         coreid_oe;
   logic [zxuno_pkg::DATA_W-1:0] coreid_dout;
   logic                         options_oe;
   logic [zxuno_pkg::DATA_W-1:0] options_dout;
   logic                         raster_oe;
   logic [zxuno_pkg::DATA_W-1:0] raster_dout;
   logic                         scandbl_oe;
   logic [zxuno_pkg::DATA_W-1:0] scandbl_dout;
   logic                         disable_specdrum;

   zxuno_bus_ctrl u_bus_ctrl (
      .clk             (cpuclkplain),
      .rst             (rst),
      .a               (a),
      .iorq_n          (iorq_n),
      .rd_n            (rd_n),
      .wr_n            (wr_n),
      .din             (din),
      .coreid_oe       (coreid_oe),
      .coreid_dout     (coreid_dout),
      .options_oe      (options_oe),
      .options_dout    (options_dout),
      .raster_oe       (raster_oe),
      .raster_dout     (raster_dout),
      .scandbl_oe      (scandbl_oe),
      .scandbl_dout    (scandbl_dout),
      .dout            (dout),
      .zxuno_addr      (zxuno_addr),
      .zxuno_regrd     (zxuno_regrd),
      .zxuno_regwr     (zxuno_regwr),
      .regaddr_changed (regaddr_changed),
      .data_rd         (data_rd)
   );

   coreid u_coreid (
      .clk             (cpuclkplain),
      .rst             (rst),
      .zxuno_addr      (zxuno_addr),
      .zxuno_regrd     (zxuno_regrd),
      .regaddr_changed (regaddr_changed),
      .data_rd         (data_rd),
      .dout            (coreid_dout),
      .oe              (coreid_oe)
   );

   option_regs u_option_regs (
      .clk              (cpuclkplain),
      .rst              (rst),
      .zxuno_addr       (zxuno_addr),
      .zxuno_regwr      (zxuno_regwr),
      .data_rd          (data_rd),
      .din              (din),
      .dout             (options_dout),
      .oe               (options_oe),
      .disable_specdrum (disable_specdrum)
   );

   rasterint_ctrl u_rasterint_ctrl (
      .clk                    (cpuclkplain),
      .rst                    (rst),
      .zxuno_addr             (zxuno_addr),
      .zxuno_regwr            (zxuno_regwr),
      .data_rd                (data_rd),
      .din                    (din),
      .raster_int_in_progress (raster_int_in_progress),
      .dout                   (raster_dout),
      .oe                     (raster_oe),
      .raster_line            (raster_line),
      .rasterint_enable       (rasterint_enable),
      .vretraceint_disable    (vretraceint_disable)
   );

   scandoubler_ctrl u_scandoubler_ctrl (
      .clk                 (cpuclkplain),
      .rst                 (rst),
      .zxuno_addr          (zxuno_addr),
      .zxuno_regwr         (zxuno_regwr),
      .data_rd             (data_rd),
      .din                 (din),
      .video_output_change (video_output_change),
      .dout                (scandbl_dout),
      .oe                  (scandbl_oe),
      .vga_enable          (vga_enable),
      .scanlines_enable    (scanlines_enable),
      .freq_option         (freq_option),
      .turbo_enable        (turbo_enable),
      .csync_option        (csync_option)
   );

   // Drum DAC sits directly on the I/O bus
   specdrum u_specdrum (
      .clk              (cpuclkplain),
      .rst              (rst),
      .a                (a),
      .iorq_n           (iorq_n),
      .wr_n             (wr_n),
      .din              (din),
      .disable_specdrum (disable_specdrum),
      .specdrum_audio   (specdrum_audio)
   );

endmodule

// ==== sources.f ====
hdl/zxuno_pkg.sv
hdl/zxuno_bus_ctrl.sv
hdl/coreid.sv
hdl/option_regs.sv
hdl/rasterint_ctrl.sv
hdl/scandoubler_ctrl.sv
hdl/specdrum.sv
hdl/zxuno_regbank.sv
bench/zxuno_regbank_asserts.sv
bench/tb_zxuno_regbank.sv
